//--- hw/sdrc_geom_pkg.sv
package sdrc_geom_pkg;

  // --------------------------------------------------
  // Device geometry, 4 banks x 4096 rows x 256 cols
  // --------------------------------------------------
  localparam int DQ_W      = 16;              // Data bus width
  localparam int BA_W      = 2;               // Bank select bits
  localparam int NUM_BANKS = 4;               // Banks per device
  localparam int ROW_W     = 12;              // Row address bits
  localparam int COL_W     = 8;               // Column address bits
  localparam int APP_AW    = BA_W + ROW_W + COL_W; // {bank, row, col} word address

  // --------------------------------------------------
  // Timing in controller clocks
  // --------------------------------------------------
  localparam int T_RP          = 2;           // PRE to next command
  localparam int T_RCD         = 2;           // ACT to RD/WR
  localparam int CAS_LAT       = 2;           // RD to data on DQ
  localparam int T_RFC         = 7;           // REF to next command
  localparam int T_WR          = 2;           // Last write data to PRE
  localparam int RFSH_INTERVAL = 200;         // Short interval for simulation
  localparam int INIT_WAIT     = 100;         // Power-up stable time
  localparam int INIT_RFSH     = 2;           // Refreshes in init sequence

  localparam logic [ROW_W-1:0] MODE_REG = 12'h020; // BL1, sequential, CL2
  localparam int AP_BIT = 10;                 // A10 selects all banks on PRE
  localparam int WAIT_W = 8;                  // Command wait counter width

  localparam int RFSH_CNT_W = $clog2(RFSH_INTERVAL);  // Refresh interval counter
  localparam int INIT_CNT_W = $clog2(INIT_RFSH + 1);  // Init refresh counter

endpackage

//--- hw/sdrc_cmd_pkg.sv
package sdrc_cmd_pkg;

  // --------------------------------------------------
  // Commands seen on the SDRAM pins
  // --------------------------------------------------
  typedef enum logic [2:0] {
    CMD_NOP,                                  // ras/cas/we = 111
    CMD_ACT,                                  // 011, open row
    CMD_RD,                                   // 101, column read
    CMD_WR,                                   // 100, column write
    CMD_PRE,                                  // 010, close row(s)
    CMD_REF,                                  // 001, auto-refresh
    CMD_MRS                                   // 000, mode register load
  } sdr_cmd_e;

  // --------------------------------------------------
  // Controller FSM states
  // --------------------------------------------------
  typedef enum logic [3:0] {
    S_INIT_WAIT, S_INIT_PRE, S_INIT_REF, S_INIT_MRS,  // Power-up
    S_IDLE,                                           // Arbitration point
    S_REF_PRE, S_REF,                                 // Periodic refresh
    S_PRE, S_ACT, S_RD, S_RD_WAIT, S_WR,              // Transfer
    S_WAIT                                            // Timed spacing
  } ctl_state_e;

endpackage

//--- hw/sdrc_req_port.sv
`timescale 1ns/1ps

module sdrc_req_port
  import sdrc_geom_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic [APP_AW-1:0] addr,
  input  logic              wr,
  input  logic [DQ_W-1:0]   wr_data,
  input  logic              take,             // FSM accepts request
  input  logic              done,             // FSM finished transfer
  input  logic              rd_valid,
  input  logic [DQ_W-1:0]   rd_data_in,
  output logic              ack,
  output logic [DQ_W-1:0]   rd_data,
  output logic              pending,
  output logic [BA_W-1:0]   bank,
  output logic [ROW_W-1:0]  row,
  output logic [COL_W-1:0]  col,
  output logic              is_write,
  output logic [DQ_W-1:0]   wdata
);

  logic              busy;                    // Taken, not yet done
  logic [APP_AW-1:0] addr_q;
  logic              wr_q;
  logic [APP_AW-1:0] addr_sel;

  assign pending  = req & ~busy & ~ack;       // Blocked while ack held
  assign addr_sel = busy ? addr_q : addr;     // Live fields on the take cycle
  assign bank     = addr_sel[APP_AW-1 -: BA_W];
  assign row      = addr_sel[COL_W +: ROW_W];
  assign col      = addr_sel[COL_W-1:0];
  assign is_write = busy ? wr_q : wr;

  // Handshake state
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      ack  <= 1'b0;
    end else if (done) begin
      busy <= 1'b0;
      ack  <= 1'b1;
    end else begin
      if (take) busy <= 1'b1;
      if (ack && !req) ack <= 1'b0;           // Falls after req drops
    end
  end

  // Request and read data holding
  always_ff @(posedge clk) begin
    if (take) begin
      addr_q <= addr;
      wr_q   <= wr;
      wdata  <= wr_data;
    end
    if (rd_valid) rd_data <= rd_data_in;      // Held through ack
  end

endmodule

//--- hw/sdrc_bank_track.sv
`timescale 1ns/1ps

module sdrc_bank_track
  import sdrc_geom_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [BA_W-1:0]  bank,              // Bank of current request
  input  logic [ROW_W-1:0] row,
  input  logic             act_issue,         // ACT to bank
  input  logic             pre_issue,         // PRE to bank
  input  logic             pre_all,           // PRE all banks
  output logic             row_hit,
  output logic             row_open
);

  logic [NUM_BANKS-1:0] open_vld;             // Row open per bank
  logic [ROW_W-1:0]     open_row [NUM_BANKS]; // Which row

  assign row_open = open_vld[bank];
  assign row_hit  = open_vld[bank] && (open_row[bank] == row);

  // Valid flags
  always_ff @(posedge clk) begin
    if (rst) begin
      open_vld <= '0;
    end else if (pre_all) begin
      open_vld <= '0;                         // Refresh or init
    end else if (pre_issue) begin
      open_vld[bank] <= 1'b0;
    end else if (act_issue) begin
      open_vld[bank] <= 1'b1;
    end
  end

  // Row registers
  always_ff @(posedge clk) begin
    if (act_issue) open_row[bank] <= row;
  end

endmodule

//--- hw/sdrc_timers.sv
`timescale 1ns/1ps

module sdrc_timers
  import sdrc_geom_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rfsh_issue,       // REF just issued
  input  logic              wait_load,
  input  logic [WAIT_W-1:0] wait_cycles,      // Nonzero spacing
  output logic              rfsh_due,
  output logic              wait_done
);

  logic [RFSH_CNT_W-1:0] rfsh_cnt;            // Cycles since last REF
  logic [WAIT_W-1:0]     wait_cnt;            // Cycles left

  // --------------------------------------------------
  // Refresh interval
  // --------------------------------------------------
  assign rfsh_due = (rfsh_cnt == RFSH_CNT_W'(RFSH_INTERVAL - 1));  // Sticky

  always_ff @(posedge clk) begin
    if (rst) begin
      rfsh_cnt <= '0;
    end else if (rfsh_issue) begin
      rfsh_cnt <= '0;
    end else if (!rfsh_due) begin             // Hold until serviced
      rfsh_cnt <= rfsh_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // Command spacing
  // --------------------------------------------------
  assign wait_done = (wait_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (wait_load) begin
      wait_cnt <= wait_cycles - 1'b1;         // Zero after wait_cycles clocks
    end else if (!wait_done) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

endmodule

//--- hw/sdrc_data_path.sv
`timescale 1ns/1ps

module sdrc_data_path
  import sdrc_geom_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [DQ_W-1:0] wdata,              // Latched write word
  input  logic            wr_issue,           // WRITE on pins this cycle
  input  logic            rd_issue,           // READ on pins this cycle
  input  logic [DQ_W-1:0] sdr_din,
  output logic [DQ_W-1:0] sdr_dout,
  output logic            sdr_den_n,
  output logic            rd_valid,
  output logic [DQ_W-1:0] rd_data
);

  logic [CAS_LAT:0] rd_pipe;                  // One bit per clock since READ

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------
  assign sdr_dout  = wdata;
  assign sdr_den_n = ~wr_issue;               // Drive DQ with the command

  // --------------------------------------------------
  // Read side
  // --------------------------------------------------
  // Data sits on DQ CAS_LAT clocks after READ
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe <= {rd_pipe[CAS_LAT-1:0], rd_issue};
    end
  end

  // Capture on the CAS edge
  always_ff @(posedge clk) begin
    if (rd_pipe[CAS_LAT-1]) rd_data <= sdr_din;
  end

  assign rd_valid = rd_pipe[CAS_LAT];         // CAS_LAT + 1 after issue

endmodule

//--- hw/sdrc_cmd_fsm.sv
`timescale 1ns/1ps

module sdrc_cmd_fsm
  import sdrc_geom_pkg::*, sdrc_cmd_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              pending,          // Request waiting at port
  input  logic [BA_W-1:0]   bank,
  input  logic [ROW_W-1:0]  row,
  input  logic [COL_W-1:0]  col,
  input  logic              is_write,
  input  logic              row_hit,          // Open row matches
  input  logic              row_open,         // Bank has a row open
  input  logic              rfsh_due,
  input  logic              wait_done,
  input  logic              rd_valid,
  output logic              take,
  output logic              done,
  output logic              act_issue,
  output logic              pre_issue,
  output logic              pre_all,
  output logic              rfsh_issue,
  output logic              wait_load,
  output logic [WAIT_W-1:0] wait_cycles,
  output logic              wr_issue,
  output logic              rd_issue,
  output logic              init_done,
  output logic              sdr_cke,
  output logic              sdr_cs_n,
  output logic              sdr_ras_n,
  output logic              sdr_cas_n,
  output logic              sdr_we_n,
  output logic [BA_W-1:0]   sdr_ba,
  output logic [ROW_W-1:0]  sdr_addr
);

  localparam logic [ROW_W-1:0] AP_ALL = ROW_W'(1) << AP_BIT;  // PRE all banks

  ctl_state_e            state, state_nx;
  ctl_state_e            ret_state, ret_nx;   // Where S_WAIT returns to
  sdr_cmd_e              cmd;
  logic                  wr_fin;              // Write recovery in progress
  logic [INIT_CNT_W-1:0] init_cnt;            // Init refreshes issued

  // --------------------------------------------------
  // Next state and command select
  // --------------------------------------------------
  always_comb begin
    state_nx    = state;
    ret_nx      = ret_state;
    cmd         = CMD_NOP;
    take        = 1'b0;
    act_issue   = 1'b0;
    pre_issue   = 1'b0;
    pre_all     = 1'b0;
    rfsh_issue  = 1'b0;
    wr_issue    = 1'b0;
    rd_issue    = 1'b0;
    wait_load   = 1'b0;
    wait_cycles = '0;
    case (state)
      S_INIT_WAIT: begin                       // Power-up settle
        wait_load = 1'b1; wait_cycles = WAIT_W'(INIT_WAIT - 1); ret_nx = S_INIT_PRE;
      end
      S_INIT_PRE, S_REF_PRE: begin             // Close everything
        cmd = CMD_PRE; pre_all = 1'b1;
        wait_load = 1'b1; wait_cycles = WAIT_W'(T_RP - 1);
        ret_nx = (state == S_INIT_PRE) ? S_INIT_REF : S_REF;
      end
      S_INIT_REF: begin
        cmd = CMD_REF; rfsh_issue = 1'b1;
        wait_load = 1'b1; wait_cycles = WAIT_W'(T_RFC - 1);
        ret_nx = (init_cnt == INIT_CNT_W'(INIT_RFSH - 1)) ? S_INIT_MRS : S_INIT_REF;
      end
      S_INIT_MRS: begin                        // Last init step
        cmd = CMD_MRS; state_nx = S_IDLE;
      end
      S_IDLE: begin
        if (rfsh_due) begin                    // Refresh wins over requests
          state_nx = S_REF_PRE;
        end else if (pending) begin
          take = 1'b1;
          if (row_hit) state_nx = is_write ? S_WR : S_RD;  // Page hit
          else if (row_open) state_nx = S_PRE;             // Wrong row open
          else state_nx = S_ACT;                           // Bank idle
        end
      end
      S_REF: begin
        cmd = CMD_REF; rfsh_issue = 1'b1;
        wait_load = 1'b1; wait_cycles = WAIT_W'(T_RFC - 1); ret_nx = S_IDLE;
      end
      S_PRE: begin                             // Single-bank precharge
        cmd = CMD_PRE; pre_issue = 1'b1;
        wait_load = 1'b1; wait_cycles = WAIT_W'(T_RP - 1); ret_nx = S_ACT;
      end
      S_ACT: begin
        cmd = CMD_ACT; act_issue = 1'b1;
        wait_load = 1'b1; wait_cycles = WAIT_W'(T_RCD - 1);
        ret_nx = is_write ? S_WR : S_RD;
      end
      S_RD: begin
        cmd = CMD_RD; rd_issue = 1'b1; state_nx = S_RD_WAIT;
      end
      S_RD_WAIT: if (rd_valid) state_nx = S_IDLE;  // Data captured
      S_WR: begin                              // Data driven this cycle
        cmd = CMD_WR; wr_issue = 1'b1;
        wait_load = 1'b1; wait_cycles = WAIT_W'(T_WR - 1); ret_nx = S_IDLE;
      end
      S_WAIT: if (wait_done) state_nx = ret_state;
      default: state_nx = S_INIT_WAIT;         // Unused encodings
    endcase
    if (wait_load) state_nx = S_WAIT;          // All timed commands park here
  end

  // --------------------------------------------------
  // Pin decode
  // --------------------------------------------------
  assign sdr_cke  = 1'b1;                      // No power-down support
  assign sdr_cs_n = 1'b0;                      // Single device, always selected

  always_comb begin
    sdr_ba   = '0;
    sdr_addr = '0;
    {sdr_ras_n, sdr_cas_n, sdr_we_n} = 3'b111;  // NOP
    case (cmd)
      CMD_ACT: begin
        {sdr_ras_n, sdr_cas_n, sdr_we_n} = 3'b011; sdr_ba = bank; sdr_addr = row;
      end
      CMD_RD: begin                            // A10 low, no auto-precharge
        {sdr_ras_n, sdr_cas_n, sdr_we_n} = 3'b101; sdr_ba = bank; sdr_addr = ROW_W'(col);
      end
      CMD_WR: begin
        {sdr_ras_n, sdr_cas_n, sdr_we_n} = 3'b100; sdr_ba = bank; sdr_addr = ROW_W'(col);
      end
      CMD_PRE: begin
        {sdr_ras_n, sdr_cas_n, sdr_we_n} = 3'b010;
        sdr_ba   = bank;
        sdr_addr = pre_all ? AP_ALL : '0;      // A10 picks all or one
      end
      CMD_REF: {sdr_ras_n, sdr_cas_n, sdr_we_n} = 3'b001;
      CMD_MRS: begin
        {sdr_ras_n, sdr_cas_n, sdr_we_n} = 3'b000; sdr_addr = MODE_REG;
      end
      default: ;                               // NOP
    endcase
  end

  // --------------------------------------------------
  // State and status registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_INIT_WAIT;
      ret_state <= S_IDLE;
      init_done <= 1'b0;
      done      <= 1'b0;
      wr_fin    <= 1'b0;
      init_cnt  <= '0;
    end else begin
      state     <= state_nx;
      ret_state <= ret_nx;
      done      <= 1'b0;                        // Single-cycle pulse
      if (state == S_INIT_MRS) init_done <= 1'b1;
      if (state == S_INIT_REF) init_cnt <= init_cnt + 1'b1;
      if (state == S_WR) wr_fin <= 1'b1;
      if (state == S_WAIT && wait_done && wr_fin) begin  // tWR elapsed
        done   <= 1'b1;
        wr_fin <= 1'b0;
      end
      if (state == S_RD_WAIT && rd_valid) done <= 1'b1;  // One after rd_valid
    end
  end

endmodule

//--- hw/sdrc_core.sv
`timescale 1ns/1ps

module sdrc_core
  import sdrc_geom_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // Application side
  input  logic              req,              // Four-phase request
  input  logic [APP_AW-1:0] addr,             // Word address
  input  logic              wr,               // 1 - write, 0 - read
  input  logic [DQ_W-1:0]   wr_data,
  output logic              ack,
  output logic [DQ_W-1:0]   rd_data,
  output logic              init_done,
  // SDRAM pins
  output logic              sdr_cke,
  output logic              sdr_cs_n,
  output logic              sdr_ras_n,
  output logic              sdr_cas_n,
  output logic              sdr_we_n,
  output logic [BA_W-1:0]   sdr_ba,
  output logic [ROW_W-1:0]  sdr_addr,
  output logic [DQ_W-1:0]   sdr_dout,
  output logic              sdr_den_n,        // Low while driving DQ
  input  logic [DQ_W-1:0]   sdr_din
);

  // --------------------------------------------------
  // Internal nets
  // --------------------------------------------------
  logic              take, done, pending, is_write;
  logic [BA_W-1:0]   bank;
  logic [ROW_W-1:0]  row;
  logic [COL_W-1:0]  col;
  logic [DQ_W-1:0]   wdata, dp_rd_data;
  logic              row_hit, row_open;       // Bank tracker status
  logic              act_issue, pre_issue, pre_all;
  logic              rfsh_due, rfsh_issue;
  logic              wait_load, wait_done;
  logic [WAIT_W-1:0] wait_cycles;
  logic              wr_issue, rd_issue, rd_valid;

  sdrc_req_port u_req_port (
    .clk, .rst, .req, .addr, .wr, .wr_data, .take, .done, .rd_valid,
    .rd_data_in (dp_rd_data),                 // Word from read capture
    .ack, .rd_data, .pending, .bank, .row, .col, .is_write, .wdata
  );

  sdrc_cmd_fsm u_cmd_fsm (
    .clk, .rst, .pending, .bank, .row, .col, .is_write, .row_hit, .row_open,
    .rfsh_due, .wait_done, .rd_valid,
    .take, .done, .act_issue, .pre_issue, .pre_all, .rfsh_issue,
    .wait_load, .wait_cycles, .wr_issue, .rd_issue, .init_done,
    .sdr_cke, .sdr_cs_n, .sdr_ras_n, .sdr_cas_n, .sdr_we_n, .sdr_ba, .sdr_addr
  );

  sdrc_bank_track u_bank_track (
    .clk, .rst, .bank, .row, .act_issue, .pre_issue, .pre_all,
    .row_hit, .row_open
  );

  sdrc_timers u_timers (
    .clk, .rst, .rfsh_issue, .wait_load, .wait_cycles,
    .rfsh_due, .wait_done
  );

  sdrc_data_path u_data_path (
    .clk, .rst, .wdata, .wr_issue, .rd_issue, .sdr_din,
    .sdr_dout, .sdr_den_n, .rd_valid,
    .rd_data (dp_rd_data)
  );

endmodule

//--- sim/sdram_model.sv
`timescale 1ns/1ps

module sdram_model
  import sdrc_geom_pkg::*, sdrc_cmd_pkg::*;
(
  input  logic             clk,
  input  logic             cke,
  input  logic             cs_n,
  input  logic             ras_n,
  input  logic             cas_n,
  input  logic             we_n,
  input  logic [BA_W-1:0]  ba,
  input  logic [ROW_W-1:0] a,
  input  logic [DQ_W-1:0]  dq_in,             // Controller drive
  input  logic             den_n,
  output logic [DQ_W-1:0]  dq_out
);

  logic [DQ_W-1:0]   mem [logic [APP_AW-1:0]];  // Only written words stored
  logic [ROW_W-1:0]  act_row [NUM_BANKS];       // Row opened by last ACT
  logic [ROW_W-1:0]  mode_val;
  logic [DQ_W-1:0]   rd_stage;                  // First CAS stage
  logic [APP_AW-1:0] key;
  sdr_cmd_e          cmd;
  sdr_cmd_e          log_q [$];                 // Non-NOP commands in order
  int                n_cmd [8];                 // Per-command totals

  // Unwritten words read back as a pattern of the whole address
  function automatic logic [DQ_W-1:0] fill(logic [APP_AW-1:0] k);
    return k[DQ_W-1:0] ^ DQ_W'(k >> DQ_W) ^ 16'h5a5a;
  endfunction

  always_comb begin
    case ({cs_n, ras_n, cas_n, we_n})
      4'b0011: cmd = CMD_ACT;
      4'b0101: cmd = CMD_RD;
      4'b0100: cmd = CMD_WR;
      4'b0010: cmd = CMD_PRE;
      4'b0001: cmd = CMD_REF;
      4'b0000: cmd = CMD_MRS;
      default: cmd = CMD_NOP;                 // Deselect or NOP
    endcase
    if (!cke) cmd = CMD_NOP;
  end

  assign key = {ba, act_row[ba], a[COL_W-1:0]};

  initial begin
    mode_val = '0;
    rd_stage = '0;
    dq_out   = '0;                            // DQ quiet until the first READ
    foreach (n_cmd[i]) n_cmd[i] = 0;
  end

  // --------------------------------------------------
  // Command execution on the rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    if (cmd == CMD_RD) rd_stage <= mem.exists(key) ? mem[key] : fill(key);
    dq_out <= rd_stage;                       // On DQ for the CAS_LAT edge
    if (cmd != CMD_NOP) begin
      log_q.push_back(cmd);
      n_cmd[cmd]++;
    end
    case (cmd)
      CMD_ACT: act_row[ba] = a;
      CMD_WR:  if (!den_n) mem[key] = dq_in;  // Data comes with the command
      CMD_MRS: mode_val = a;
      default: ;
    endcase
  end

endmodule

//--- sim/sdrc_sva.sv
`timescale 1ns/1ps

module sdrc_sva
  import sdrc_geom_pkg::*, sdrc_cmd_pkg::*;
(
  input logic             clk,
  input logic             rst,
  input logic             req,
  input logic             ack,
  input logic             init_done,
  input logic             sdr_cs_n,
  input logic             sdr_ras_n,
  input logic             sdr_cas_n,
  input logic             sdr_we_n,
  input logic [BA_W-1:0]  sdr_ba,
  input logic [ROW_W-1:0] sdr_addr
);

  sdr_cmd_e             cmd;
  logic [NUM_BANKS-1:0] open_vld;             // Banks with a row open
  int                   act_age [NUM_BANKS];  // Clocks since ACT up to 15

  always_comb begin
    case ({sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n})
      4'b0011: cmd = CMD_ACT;
      4'b0101: cmd = CMD_RD;
      4'b0100: cmd = CMD_WR;
      4'b0010: cmd = CMD_PRE;
      4'b0001: cmd = CMD_REF;
      4'b0000: cmd = CMD_MRS;
      default: cmd = CMD_NOP;
    endcase
  end

  // Bank state rebuilt from the pins
  always_ff @(posedge clk) begin
    if (rst) begin
      open_vld <= '0;
      for (int i = 0; i < NUM_BANKS; i++) begin
        act_age[i] <= 15;
      end
    end else begin
      for (int i = 0; i < NUM_BANKS; i++) begin
        if (act_age[i] < 15) act_age[i] <= act_age[i] + 1;
      end
      if (cmd == CMD_ACT) begin
        open_vld[sdr_ba] <= 1'b1;
        act_age[sdr_ba]  <= 1;                // Overrides the increment
      end
      if (cmd == CMD_PRE) begin
        if (sdr_addr[AP_BIT]) open_vld <= '0; // All banks
        else open_vld[sdr_ba] <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Properties
  // --------------------------------------------------
  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  a_no_access_before_init: assert property (@(posedge clk) disable iff (rst)
    !init_done |-> !(cmd inside {CMD_ACT, CMD_RD, CMD_WR}))
    else $error("row or column command before init_done");

  a_trcd: assert property (@(posedge clk) disable iff (rst)
    (cmd inside {CMD_RD, CMD_WR}) |-> act_age[sdr_ba] >= T_RCD)
    else $error("column command inside tRCD of its ACT");

  a_ref_all_closed: assert property (@(posedge clk) disable iff (rst)
    cmd == CMD_REF |-> open_vld == '0)
    else $error("refresh with a bank still open");

endmodule

//--- sim/tb_sdrc_core.sv
`timescale 1ns/1ps

module tb_sdrc_core
  import sdrc_geom_pkg::*, sdrc_cmd_pkg::*;
();

  localparam int CLK_NS     = 4;
  localparam int N_RAND     = 16;             // Random writes each read back
  localparam int N_XFER     = 47;             // All transfers in the run
  localparam int XFER_TMO   = 60;             // Cycles from req to ack
  localparam int HOLD_CYC   = 40;             // Back-pressure hold
  localparam int INIT_BOUND = INIT_WAIT + T_RP + INIT_RFSH * T_RFC + 20;
  localparam int WDOG_CYC   = N_XFER * 40 + INIT_BOUND + 3 * RFSH_INTERVAL
                              + 2 * HOLD_CYC + 500;
  // BL1 sequential with CAS latency in A6..A4
  localparam logic [ROW_W-1:0] EXP_MODE = {5'b0, 3'(CAS_LAT), 1'b0, 3'b000};

  logic              clk, rst, req, wr, ack, init_done;
  logic [APP_AW-1:0] addr;
  logic [DQ_W-1:0]   wr_data, rd_data, sdr_dout, sdr_din;
  logic              sdr_cke, sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n, sdr_den_n;
  logic [BA_W-1:0]   sdr_ba;
  logic [ROW_W-1:0]  sdr_addr;

  logic [31:0]          lfsr = 32'h37a6;
  logic [DQ_W-1:0]      sb [logic [APP_AW-1:0]];  // Expected memory contents
  logic [NUM_BANKS-1:0] pred_vld = '0;            // Predicted open rows
  logic [ROW_W-1:0]     pred_row [NUM_BANKS];
  int                   log_pos, n_err, n_checks, n_tests;

  sdrc_core uut (
    .clk, .rst, .req, .addr, .wr, .wr_data, .ack, .rd_data, .init_done,
    .sdr_cke, .sdr_cs_n, .sdr_ras_n, .sdr_cas_n, .sdr_we_n, .sdr_ba, .sdr_addr,
    .sdr_dout, .sdr_den_n, .sdr_din
  );

  sdram_model mdl (
    .clk, .cke (sdr_cke), .cs_n (sdr_cs_n), .ras_n (sdr_ras_n), .cas_n (sdr_cas_n),
    .we_n (sdr_we_n), .ba (sdr_ba), .a (sdr_addr), .dq_in (sdr_dout),
    .den_n (sdr_den_n), .dq_out (sdr_din)
  );

  bind sdrc_core sdrc_sva u_sva (
    .clk (clk), .rst (rst), .req (req), .ack (ack), .init_done (init_done),
    .sdr_cs_n (sdr_cs_n), .sdr_ras_n (sdr_ras_n), .sdr_cas_n (sdr_cas_n),
    .sdr_we_n (sdr_we_n), .sdr_ba (sdr_ba), .sdr_addr (sdr_addr)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic lfsr_step();       // Galois LFSR with taps 32 22 2 1
    logic b;
    b = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic logic [APP_AW-1:0] mk_addr(logic [BA_W-1:0] b, logic [ROW_W-1:0] r,
                                                logic [COL_W-1:0] c);
    return {b, r, c};
  endfunction

  task automatic check_data(string name, logic [DQ_W-1:0] got, logic [DQ_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  task automatic check_cmd(string name, sdr_cmd_e got, sdr_cmd_e exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    n_checks++;
    if (got != exp) begin
      n_err++;
      $display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  task automatic report_test(string name, int err_start);
    n_tests++;
    if (n_err == err_start) $display("%s: ok", name);
    else $display("%s: %0d errors", name, n_err - err_start);
  endtask

  // One four-phase transfer with page-rule prediction and optional hold
  task automatic xfer(logic w, logic [APP_AW-1:0] a, logic [DQ_W-1:0] d, int hold);
    int n, n_act, n_pre, n_col, col_cnt;
    logic ref_before, ref_after, exp_act, exp_pre;
    logic [BA_W-1:0] bk;
    logic [ROW_W-1:0] rw;
    bk = a[APP_AW-1 -: BA_W];
    rw = a[COL_W +: ROW_W];
    @(negedge clk);
    req = 1'b1;
    addr = a;
    wr = w;
    wr_data = d;
    n = 0;
    while (!ack && n < XFER_TMO) begin
      @(negedge clk);
      n++;
    end
    if (!ack) begin
      n_err++;
      $display("no ack for address 0x%h within %0d cycles", a, XFER_TMO);
      req = 1'b0;
      return;
    end
    if (!w) check_data("rd_data", rd_data, sb[a]);
    if (w) sb[a] = d;
    col_cnt = mdl.n_cmd[CMD_RD] + mdl.n_cmd[CMD_WR];
    for (int i = 0; i < hold; i++) begin     // Back-pressure with req kept high
      @(negedge clk);
      if (!ack) begin
        n_err++;
        $display("ack dropped while req was still held");
      end
    end
    if (hold > 0) begin
      check_count("rd/wr during hold", mdl.n_cmd[CMD_RD] + mdl.n_cmd[CMD_WR], col_cnt);
    end
    req = 1'b0;
    @(negedge clk);
    if (ack) begin
      n_err++;
      $display("ack still high one cycle after req dropped");
    end
    // Walk the model's command log since the previous transfer
    n_act = 0;
    n_pre = 0;
    n_col = 0;
    ref_before = 1'b0;
    ref_after = 1'b0;
    for (int i = log_pos; i < mdl.log_q.size(); i++) begin
      case (mdl.log_q[i])
        CMD_REF: begin
          if (n_col == 0) ref_before = 1'b1;
          else ref_after = 1'b1;
        end
        CMD_ACT: n_act++;
        CMD_PRE: begin                        // Refresh PRE-all is followed by REF
          if (i + 1 < mdl.log_q.size() && mdl.log_q[i+1] == CMD_ACT) n_pre++;
        end
        CMD_RD, CMD_WR: n_col++;
        default: ;
      endcase
    end
    log_pos = mdl.log_q.size();
    if (ref_before) pred_vld = '0;
    exp_act = !(pred_vld[bk] && pred_row[bk] == rw);
    exp_pre = pred_vld[bk] && pred_row[bk] != rw;  // Miss on an open bank
    check_count("ACT count", n_act, exp_act ? 1 : 0);
    check_count("PRE count", n_pre, exp_pre ? 1 : 0);
    check_count("column command count", n_col, 1);
    pred_vld[bk] = 1'b1;
    pred_row[bk] = rw;
    if (ref_after) pred_vld = '0;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_init();
    int e0, n;
    e0 = n_err;
    n = 0;
    while (!init_done && n < INIT_BOUND) begin
      @(negedge clk);
      n++;
    end
    if (!init_done) begin
      n_err++;
      $display("init_done did not rise within %0d cycles", INIT_BOUND);
    end
    check_count("init command total", mdl.log_q.size(), INIT_RFSH + 2);
    if (mdl.log_q.size() == INIT_RFSH + 2) begin
      check_cmd("init first command", mdl.log_q[0], CMD_PRE);
      for (int i = 1; i <= INIT_RFSH; i++) begin
        check_cmd("init refresh", mdl.log_q[i], CMD_REF);
      end
      check_cmd("init last command", mdl.log_q[INIT_RFSH+1], CMD_MRS);
    end
    check_count("mode register", int'(mdl.mode_val), int'(EXP_MODE));
    log_pos = mdl.log_q.size();
    report_test("init", e0);
  endtask

  task automatic test_wr_rd();
    int e0;
    e0 = n_err;
    xfer(1'b1, mk_addr(2'd1, 12'h0a5, 8'h3c), 16'hbeef, 0);
    xfer(1'b0, mk_addr(2'd1, 12'h0a5, 8'h3c), 16'h0000, 0);
    report_test("write_read", e0);
  endtask

  task automatic test_page();
    int e0;
    e0 = n_err;
    xfer(1'b1, mk_addr(2'd2, 12'd5, 8'd1), 16'h1111, 0);  // Idle bank
    xfer(1'b1, mk_addr(2'd2, 12'd5, 8'd2), 16'h2222, 0);  // Hit
    xfer(1'b1, mk_addr(2'd2, 12'd9, 8'd3), 16'h3333, 0);  // Open bank miss
    xfer(1'b1, mk_addr(2'd3, 12'd9, 8'd3), 16'h4444, 0);
    xfer(1'b0, mk_addr(2'd2, 12'd5, 8'd1), 16'h0000, 0);
    xfer(1'b0, mk_addr(2'd2, 12'd5, 8'd2), 16'h0000, 0);
    xfer(1'b0, mk_addr(2'd2, 12'd9, 8'd3), 16'h0000, 0);  // Same row and column as bank 3
    report_test("page_rule", e0);
  endtask

  task automatic test_random();
    int e0;
    logic [APP_AW-1:0] addrs [$];
    logic [APP_AW-1:0] a;
    e0 = n_err;
    for (int i = 0; i < N_RAND; i++) begin   // Few rows so hits and misses mix
      a = mk_addr(BA_W'(rand_bits(BA_W)), ROW_W'(rand_bits(2)), COL_W'(rand_bits(COL_W)));
      addrs.push_back(a);
      xfer(1'b1, a, DQ_W'(rand_bits(DQ_W)), 0);
    end
    foreach (addrs[i]) begin
      xfer(1'b0, addrs[i], 16'h0000, 0);
    end
    report_test("random", e0);
  endtask

  task automatic test_idle_refresh();
    int e0, ref0;
    e0 = n_err;
    xfer(1'b1, mk_addr(2'd0, 12'h123, 8'h44), 16'hc0de, 0);
    xfer(1'b1, mk_addr(2'd3, 12'h456, 8'h99), 16'h0f0f, 0);
    ref0 = mdl.n_cmd[CMD_REF];
    repeat (3 * RFSH_INTERVAL) @(negedge clk);
    if (mdl.n_cmd[CMD_REF] - ref0 < 2) begin
      n_err++;
      $display("only %0d refreshes during idle", mdl.n_cmd[CMD_REF] - ref0);
    end
    xfer(1'b0, mk_addr(2'd0, 12'h123, 8'h44), 16'h0000, 0);
    xfer(1'b0, mk_addr(2'd3, 12'h456, 8'h99), 16'h0000, 0);
    report_test("idle_refresh", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = n_err;
    xfer(1'b1, mk_addr(2'd1, 12'h777, 8'h05), 16'ha5a5, HOLD_CYC);
    xfer(1'b0, mk_addr(2'd1, 12'h777, 8'h05), 16'h0000, HOLD_CYC);
    report_test("backpressure", e0);
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst = 1'b1;
    req = 1'b0;
    wr = 1'b0;
    addr = '0;
    wr_data = '0;
    n_err = 0;
    n_checks = 0;
    n_tests = 0;
    log_pos = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    test_init();
    test_wr_rd();
    test_page();
    test_random();
    test_idle_refresh();
    test_backpressure();
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
    if (n_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles", WDOG_CYC);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- list.f
hw/sdrc_geom_pkg.sv
hw/sdrc_cmd_pkg.sv
hw/sdrc_req_port.sv
hw/sdrc_bank_track.sv
hw/sdrc_timers.sv
hw/sdrc_data_path.sv
hw/sdrc_cmd_fsm.sv
hw/sdrc_core.sv
sim/sdram_model.sv
sim/sdrc_sva.sv
sim/tb_sdrc_core.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_sdrc_core -f list.f \
  && ./obj_dir/Vtb_sdrc_core | tee /dev/stderr | grep -q "TEST PASSED" \
  || { echo "simulation did not pass"; exit 1; }
